//--- design/rd_test_pkg.sv
`default_nettype none

package rd_test_pkg;

	// ########################################################################
	// Widths and lane layout

	localparam int lanes = 8;           // Expected-data byte lanes
	localparam int beat_addr_step = 8;  // Address advance per beat
	localparam int len_w = 4;           // Burst is length plus one beats
	localparam int id_w = 4;
	localparam int err_cnt_w = 8;
	localparam int prbs_seed_w = 15;    // PRBS15 register

	// ########################################################################
	// Encodings

	// Read request FSM
	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_req  = 2'd1,
		st_wait = 2'd2
	} test_state_t;

	// Expected-data mode
	typedef enum logic [1:0] {
		mode_pattern = 2'd0,
		mode_prbs    = 2'd1,
		mode_incr    = 2'd2
	} exp_mode_t;

endpackage

`default_nettype wire

//--- design/rd_req_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module rd_req_ctrl #(
	parameter int addr_w = 28
) (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire                             read_en,
	input  wire [addr_w-1:0]                rd_addr,
	input  wire [rd_test_pkg::len_w-1:0]    rd_len,
	input  wire [rd_test_pkg::id_w-1:0]     rd_id,
	input  wire                             rd_ap,
	input  wire                             arready,
	input  wire                             rvalid,
	output logic [addr_w-1:0]               araddr,
	output logic [rd_test_pkg::len_w-1:0]   arlen,
	output logic [rd_test_pkg::id_w-1:0]    arid,
	output logic                            ar_ap,
	output logic                            arvalid,
	output logic                            read_done,
	output logic                            busy,
	output logic                            addr_load,
	output rd_test_pkg::test_state_t        test_state
);

	import rd_test_pkg::*;

	localparam int cnt_w = 16;

	logic [cnt_w-1:0] req_cnt;  // Beats asked for since reset
	logic [cnt_w-1:0] ret_cnt;  // Beats returned since reset
	logic             finished;
	logic             take;
	logic             accept;

	assign finished = (req_cnt == ret_cnt);
	assign take = read_en && (test_state == st_idle) && finished;
	assign accept = arvalid && arready;
	assign busy = (test_state != st_idle);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			test_state <= st_idle;
			arvalid <= 1'b0;
			read_done <= 1'b0;
			addr_load <= 1'b0;
		end else begin
			read_done <= accept;
			addr_load <= take;  // Fields are captured on this same edge
			if (take) begin
				arvalid <= 1'b1;
			end else if (accept) begin
				arvalid <= 1'b0;
			end
			case (test_state)
				st_idle: begin
					if (take) begin
						test_state <= st_req;
					end
				end
				st_req: begin
					if (accept) begin
						test_state <= st_wait;
					end
				end
				st_wait: begin
					if (finished) begin
						test_state <= st_idle;
					end
				end
				default: test_state <= st_idle;
			endcase
		end
	end

	// Held stable while arvalid waits for arready
	always_ff @(posedge clk) begin
		if (take) begin
			araddr <= rd_addr;
			arlen <= rd_len;
			arid <= rd_id;
			ar_ap <= rd_ap;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_cnt <= '0;
			ret_cnt <= '0;
		end else begin
			if (accept) begin
				req_cnt <= req_cnt + cnt_w'(arlen) + 1'b1;
			end
			if (rvalid) begin
				ret_cnt <= ret_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/rd_beat_addr.sv
`timescale 1ns/10ps
`default_nettype none

module rd_beat_addr #(
	parameter int addr_w = 28
) (
	input  wire               clk,
	input  wire               rst_n,
	input  wire               addr_load,
	input  wire [addr_w-1:0]  araddr,
	input  wire               rvalid,
	output logic [addr_w-1:0] beat_addr
);

	import rd_test_pkg::*;

	localparam logic [addr_w-1:0] step = addr_w'(beat_addr_step);

	// ########################################################################
	// Beat address
	//
	// The address moves on the edge that ends a beat, so the next beat
	// already sees its own address

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_addr <= '0;
		end else if (addr_load) begin
			beat_addr <= araddr;  // Start of a new burst
		end else if (rvalid) begin
			beat_addr <= beat_addr + step;
		end
	end

endmodule

`default_nettype wire

//--- design/rd_exp_gen.sv
`timescale 1ns/10ps
`default_nettype none

module rd_exp_gen #(
	parameter int                                dq_w = 16,
	parameter logic [rd_test_pkg::lanes*8-1:0]   data_pattern = 64'h807f_aa55_807f_aa55
) (
	input  wire [rd_test_pkg::prbs_seed_w-1:0]   beat_addr,
	input  rd_test_pkg::exp_mode_t               exp_mode,
	output logic [dq_w*8-1:0]                    exp_data
);

	import rd_test_pkg::*;

	localparam int dq_num = dq_w / 8;        // Copies of each lane byte
	localparam int prbs_bits = lanes * 8;

	logic [prbs_seed_w-1:0] lfsr;
	logic [prbs_bits-1:0]   prbs_word;
	logic [7:0]             lane_byte [lanes];

	// ########################################################################
	// PRBS15, x^15 + x^14 + 1, reseeded from the beat address every beat

	always_comb begin
		lfsr = {beat_addr[prbs_seed_w-1:1], 1'b1};  // Bit 0 forced so the seed is never zero
		for (int n = 0; n < prbs_bits; n++) begin
			prbs_word[n] = lfsr[14] ^ lfsr[13];
			lfsr = {lfsr[13:0], prbs_word[n]};
		end
	end

	// ########################################################################
	// Lane bytes and replication across the DQ bytes

	always_comb begin
		for (int i = 0; i < lanes; i++) begin
			case (exp_mode)
				mode_prbs: lane_byte[i] = prbs_word[i*8 +: 8];
				mode_incr: lane_byte[i] = prbs_word[7:0] + 8'(i);
				default:   lane_byte[i] = data_pattern[i*8 +: 8];
			endcase
		end
	end

	always_comb begin
		for (int i = 0; i < lanes; i++) begin
			for (int j = 0; j < dq_num; j++) begin
				exp_data[(i*dq_num+j)*8 +: 8] = lane_byte[i];
			end
		end
	end

endmodule

`default_nettype wire

//--- design/rd_data_check.sv
`timescale 1ns/10ps
`default_nettype none

module rd_data_check #(
	parameter int dq_w = 16
) (
	input  wire                                 clk,
	input  wire                                 rst_n,
	input  wire                                 rvalid,
	input  wire [dq_w*8-1:0]                    rdata,
	input  wire [dq_w*8-1:0]                    exp_data,
	input  wire                                 manu_clear,
	output logic [rd_test_pkg::err_cnt_w-1:0]   err_cnt,
	output logic                                err_flag,
	output logic [dq_w*8-1:0]                   err_data_out,
	output logic [dq_w*8-1:0]                   exp_data_out,
	output logic [dq_w*8-1:0]                   err_mask_out
);

	import rd_test_pkg::*;

	localparam int data_w = dq_w * 8;

	logic              vld_d1;
	logic [data_w-1:0] rdata_d1;
	logic [data_w-1:0] exp_d1;
	logic              err_d2;    // Beat in stage two mismatched
	logic [data_w-1:0] rdata_d2;
	logic [data_w-1:0] exp_d2;
	logic [data_w-1:0] mask_d2;
	logic              clr_d1;
	logic              clr_d2;

	// ########################################################################
	// Compare pipeline

	always_ff @(posedge clk) begin
		rdata_d1 <= rdata;
		exp_d1 <= exp_data;
		rdata_d2 <= rdata_d1;
		exp_d2 <= exp_d1;
		mask_d2 <= rdata_d1 ^ exp_d1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_d1 <= 1'b0;
			err_d2 <= 1'b0;
			clr_d1 <= 1'b0;
			clr_d2 <= 1'b0;
		end else begin
			vld_d1 <= rvalid;
			err_d2 <= vld_d1 && (rdata_d1 != exp_d1);
			clr_d1 <= manu_clear;  // Clear comes from another clock domain
			clr_d2 <= clr_d1;
		end
	end

	// ########################################################################
	// Error count, sticky flag and first-error capture

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			err_cnt <= '0;
			err_flag <= 1'b0;
		end else if (clr_d2) begin
			err_cnt <= '0;
			err_flag <= 1'b0;
		end else if (err_d2) begin
			if (err_cnt != {err_cnt_w{1'b1}}) begin
				err_cnt <= err_cnt + 1'b1;
			end
			err_flag <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (err_d2 && !err_flag && !clr_d2) begin
			err_data_out <= rdata_d2;
			exp_data_out <= exp_d2;
			err_mask_out <= mask_d2;
		end
	end

endmodule

`default_nettype wire

//--- design/rd_test_top.sv
`timescale 1ns/10ps
`default_nettype none

module rd_test_top #(
	parameter int                                addr_w = 28,
	parameter int                                dq_w = 16,
	parameter logic [rd_test_pkg::lanes*8-1:0]   data_pattern = 64'h807f_aa55_807f_aa55
) (
	input  wire                                 clk,
	input  wire                                 rst_n,
	input  wire                                 read_en,
	input  wire [addr_w-1:0]                    rd_addr,
	input  wire [rd_test_pkg::len_w-1:0]        rd_len,
	input  wire [rd_test_pkg::id_w-1:0]         rd_id,
	input  wire                                 rd_ap,
	input  rd_test_pkg::exp_mode_t              exp_mode,
	input  wire                                 manu_clear,
	output wire [addr_w-1:0]                    araddr,
	output wire [rd_test_pkg::len_w-1:0]        arlen,
	output wire [rd_test_pkg::id_w-1:0]         arid,
	output wire                                 ar_ap,
	output wire                                 arvalid,
	input  wire                                 arready,
	input  wire                                 rvalid,
	input  wire [dq_w*8-1:0]                    rdata,
	output wire                                 read_done,
	output wire                                 busy,
	output rd_test_pkg::test_state_t            test_state,
	output wire [rd_test_pkg::err_cnt_w-1:0]    err_cnt,
	output wire                                 err_flag,
	output wire [dq_w*8-1:0]                    err_data_out,
	output wire [dq_w*8-1:0]                    exp_data_out,
	output wire [dq_w*8-1:0]                    err_mask_out
);

	wire                addr_load;
	wire [addr_w-1:0]   beat_addr;
	wire [dq_w*8-1:0]   exp_data;

	rd_req_ctrl #(.addr_w(addr_w)) u_req_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.read_en    (read_en),
		.rd_addr    (rd_addr),
		.rd_len     (rd_len),
		.rd_id      (rd_id),
		.rd_ap      (rd_ap),
		.arready    (arready),
		.rvalid     (rvalid),
		.araddr     (araddr),
		.arlen      (arlen),
		.arid       (arid),
		.ar_ap      (ar_ap),
		.arvalid    (arvalid),
		.read_done  (read_done),
		.busy       (busy),
		.addr_load  (addr_load),
		.test_state (test_state)
	);

	rd_beat_addr #(.addr_w(addr_w)) u_beat_addr (
		.clk        (clk),
		.rst_n      (rst_n),
		.addr_load  (addr_load),
		.araddr     (araddr),
		.rvalid     (rvalid),
		.beat_addr  (beat_addr)
	);

	// Only the low address bits seed the PRBS
	rd_exp_gen #(.dq_w(dq_w), .data_pattern(data_pattern)) u_exp_gen (
		.beat_addr  (beat_addr[rd_test_pkg::prbs_seed_w-1:0]),
		.exp_mode   (exp_mode),
		.exp_data   (exp_data)
	);

	rd_data_check #(.dq_w(dq_w)) u_data_check (
		.clk          (clk),
		.rst_n        (rst_n),
		.rvalid       (rvalid),
		.rdata        (rdata),
		.exp_data     (exp_data),
		.manu_clear   (manu_clear),
		.err_cnt      (err_cnt),
		.err_flag     (err_flag),
		.err_data_out (err_data_out),
		.exp_data_out (exp_data_out),
		.err_mask_out (err_mask_out)
	);

endmodule

`default_nettype wire

//--- verif/tb_rd_test_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rd_test_top;

	import rd_test_pkg::*;

	localparam int addr_w = 28;
	localparam int dq_w = 16;
	localparam int data_w = dq_w * 8;
	localparam int tmo = 400;                       // Cycles allowed for any one wait
	localparam int cnt_max = (1 << err_cnt_w) - 1;
	localparam logic [7:0] pat_byte [lanes] = '{8'h55, 8'haa, 8'h7f, 8'h80,
		8'h55, 8'haa, 8'h7f, 8'h80};

	logic              clk = 1'b0;
	logic              rst_n;
	logic              read_en;
	logic [addr_w-1:0] rd_addr;
	logic [len_w-1:0]  rd_len;
	logic [id_w-1:0]   rd_id;
	logic              rd_ap;
	exp_mode_t         exp_mode;
	logic              manu_clear;
	logic              arready;
	logic              rvalid;
	logic [data_w-1:0] rdata;
	wire [addr_w-1:0]  araddr;
	wire [len_w-1:0]   arlen;
	wire [id_w-1:0]    arid;
	wire               ar_ap;
	wire               arvalid;
	wire               read_done;
	wire               busy;
	test_state_t       test_state;
	wire [err_cnt_w-1:0] err_cnt;
	wire               err_flag;
	wire [data_w-1:0]  err_data_out;
	wire [data_w-1:0]  exp_data_out;
	wire [data_w-1:0]  err_mask_out;

	// Request fields and the error model shared between the processes
	logic [addr_w-1:0] exp_addr;
	logic [len_w-1:0]  exp_len;
	logic [id_w-1:0]   exp_id;
	logic              exp_ap;
	logic [15:0]       inj_mask;                    // One bit per beat of the burst
	int                inj_bit;
	int                n_req = 0;
	int                n_acc = 0;
	int                mdl_cnt = 0;
	logic              mdl_flag = 1'b0;
	logic [data_w-1:0] cap_data;
	logic [data_w-1:0] cap_exp;
	logic [data_w-1:0] cap_mask;
	logic              arvalid_q = 1'b0;

	rd_test_top #(.addr_w(addr_w), .dq_w(dq_w)) dut (.*);

	always #4 clk = ~clk;

	// ########################################################################
	// Reference model and checks

	function automatic logic [data_w-1:0] exp_word(input logic [addr_w-1:0] addr,
		input exp_mode_t mode);
		logic [14:0]       sr;
		logic [63:0]       stream;
		logic [7:0]        b;
		logic [data_w-1:0] w;
		sr = addr[14:0] | 15'd1;
		for (int n = 0; n < 64; n++) begin
			stream[n] = sr[14] ^ sr[13];  // x^15 + x^14 + 1
			sr = {sr[13:0], stream[n]};
		end
		for (int i = 0; i < lanes; i++) begin
			case (mode)
				mode_prbs: b = stream[i*8 +: 8];
				mode_incr: b = stream[7:0] + 8'(i);
				default:   b = pat_byte[i];
			endcase
			for (int k = 0; k < dq_w / 8; k++) begin
				w[(i*(dq_w/8)+k)*8 +: 8] = b;
			end
		end
		return w;
	endfunction

	task automatic check_eq(input logic [data_w-1:0] actual, input logic [data_w-1:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
			$display("Simulation finished: FAIL");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	task automatic give_up(input string what);
		$display("Timeout: %s did not happen within %0d cycles", what, tmo);
		$display("Simulation finished: FAIL");
		$fatal(1, "Timeout");
	endtask

	// Address channel. The fields must hold while arvalid waits for arready
	// Acceptance shows as arvalid falling
	always @(negedge clk) begin : compare
		logic acc;
		acc = arvalid_q && !arvalid;
		if (rst_n) begin
			check_eq(read_done, acc, "read_done");
			if (arvalid) begin
				check_eq(araddr, exp_addr, "araddr");
				check_eq(arlen, exp_len, "arlen");
				check_eq(arid, exp_id, "arid");
				check_eq(ar_ap, exp_ap, "ar_ap");
			end
			if (acc) begin
				n_acc++;
			end
		end
		arvalid_q = arvalid;
	end

	// ########################################################################
	// Memory responder

	initial begin : responder
		logic [addr_w-1:0] base;
		int                nbeats;
		logic [data_w-1:0] good;
		logic [data_w-1:0] word;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		forever begin
			@(negedge clk);
			arready = ($urandom_range(0, 3) != 0);
			if (arvalid && arready) begin
				base = araddr;
				nbeats = int'(arlen) + 1;
				@(negedge clk);
				arready = 1'b0;
				repeat ($urandom_range(0, 3)) @(negedge clk);
				for (int j = 0; j < nbeats; j++) begin
					if ($urandom_range(0, 3) == 0) begin
						rvalid = 1'b0;  // Gap between beats
						@(negedge clk);
					end
					good = exp_word(base + addr_w'(j * beat_addr_step), exp_mode);
					word = good;
					if (inj_mask[j]) begin
						word[inj_bit] = ~word[inj_bit];
						if (!mdl_flag) begin
							cap_data = word;
							cap_exp = good;
							cap_mask = word ^ good;
						end
						mdl_flag = 1'b1;
						if (mdl_cnt < cnt_max) begin
							mdl_cnt++;
						end
					end
					rvalid = 1'b1;
					rdata = word;
					@(negedge clk);
				end
				rvalid = 1'b0;
			end
		end
	end

	// ########################################################################
	// Stimulus

	task automatic run_burst(input exp_mode_t mode, input logic [len_w-1:0] len,
		input logic [15:0] mask, input logic poke);
		int t;
		exp_addr = addr_w'($urandom());
		exp_len = len;
		exp_id = id_w'($urandom());
		exp_ap = 1'($urandom());
		exp_mode = mode;
		inj_mask = mask;
		inj_bit = $urandom_range(0, data_w - 1);
		rd_addr = exp_addr;
		rd_len = exp_len;
		rd_id = exp_id;
		rd_ap = exp_ap;
		read_en = 1'b1;
		n_req++;
		@(negedge clk);
		read_en = 1'b0;
		// Request is taken, address not yet accepted
		check_eq(arvalid, 1'b1, "arvalid after read_en");
		check_eq(busy, 1'b1, "busy after read_en");
		check_eq(test_state, st_req, "test_state after read_en");
		if (poke) begin
			t = 0;
			while (!read_done) begin
				if (t == tmo) begin
					give_up("read_done for the issued request");
				end
				t++;
				@(negedge clk);
			end
			// Beats are still outstanding, so this one must be dropped
			rd_addr = ~exp_addr;
			read_en = 1'b1;
			@(negedge clk);
			read_en = 1'b0;
		end
		t = 0;
		while (busy) begin
			if (t == tmo) begin
				give_up("return of the request FSM to idle");
			end
			t++;
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		check_eq(n_acc, n_req, "accepted address count");
		check_eq(err_cnt, mdl_cnt, "err_cnt");
		check_eq(err_flag, mdl_flag, "err_flag");
		if (mdl_flag) begin
			check_eq(err_data_out, cap_data, "err_data_out");
			check_eq(exp_data_out, cap_exp, "exp_data_out");
			check_eq(err_mask_out, cap_mask, "err_mask_out");
		end
	endtask

	task automatic clear_errors();
		manu_clear = 1'b1;
		@(negedge clk);
		manu_clear = 1'b0;
		repeat (5) @(negedge clk);
		mdl_cnt = 0;
		mdl_flag = 1'b0;
		check_eq(err_cnt, '0, "err_cnt after clear");
		check_eq(err_flag, '0, "err_flag after clear");
	endtask

	initial begin : stimulus
		void'($urandom(32'h53ea_0093));
		rst_n = 1'b0;
		read_en = 1'b0;
		rd_addr = '0;
		rd_len = '0;
		rd_id = '0;
		rd_ap = 1'b0;
		exp_mode = mode_pattern;
		manu_clear = 1'b0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_eq(arvalid, '0, "arvalid after reset");
		check_eq(read_done, '0, "read_done after reset");
		check_eq(err_cnt, '0, "err_cnt after reset");
		check_eq(err_flag, '0, "err_flag after reset");
		check_eq(test_state, st_idle, "test_state after reset");
		for (int k = 0; k < 24; k++) begin
			run_burst(exp_mode_t'(k % 3), len_w'($urandom()), '0, (k % 4 == 1));
		end
		for (int k = 0; k < 6; k++) begin
			run_burst(exp_mode_t'(k % 3), len_w'($urandom()), 16'($urandom()) | 16'h1, 1'b0);
		end
		clear_errors();
		run_burst(mode_prbs, 4'd7, 16'h0004, 1'b0);  // Capture must follow the new beat
		// Long run of bad beats to reach saturation
		for (int k = 0; k < 18; k++) begin
			run_burst(exp_mode_t'(k % 3), '1, '1, (k == 0));
		end
		check_eq(err_cnt, cnt_max, "saturated err_cnt");
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- rd_test_top.f
design/rd_test_pkg.sv
design/rd_req_ctrl.sv
design/rd_beat_addr.sv
design/rd_exp_gen.sv
design/rd_data_check.sv
design/rd_test_top.sv
verif/tb_rd_test_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_rd_test_top
FILELIST  := rd_test_top.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only -Wall --timing --top-module $(TOP)
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
